// File: flist.f
+incdir+include
verilog/lcdPkg.sv
verilog/dispPkg.sv
verilog/displaySequencer.sv
verilog/lcdController.sv
verilog/lcdHexDisplay.sv
tb/tbClockGen.sv
tb/lcdHexDisplay_asserts.sv
tb/lcdHexDisplay_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the LCD hex display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
	--top-module lcdHexDisplay_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/VlcdHexDisplay_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
echo "Pass message not found in output"
exit 1

// File: tb/lcdHexDisplay_tb.sv
/*
	LCD hex display testbench
	Applies a table of register sets, logs every byte the LCD latches
	and checks the init list, the clear and the eight hex characters.
	Also checks value capture, idle bus in finish and nextString.
*/
`timescale 1ns/1ps
`default_nettype none

module lcdHexDisplay_tb;

	import lcdPkg::*;
	import dispPkg::*;

	localparam int NUM_ROWS = 8;
	localparam int INIT_TIMEOUT = 2000;
	localparam int ROW_TIMEOUT = 2000;
	localparam int BYTE_TIMEOUT = 1000;
	localparam int QUIET_CYC = 30;

	logic clkFSM;
	logic resetFSM;
	logic display;
	logic nextString;
	regSet_t values;
	lcdBus_t lcd;
	seqState_t state;

	lcdBus_t busLog[$];	// Bytes latched by the LCD
	regSet_t rowVals [NUM_ROWS];
	logic [63:0] rowChars [NUM_ROWS];	// Expected text, first char in MSB
	string rowNames [NUM_ROWS];
	logic [7:0] initExpect [4] = '{8'h38, 8'h0C, 8'h06, 8'h01};

	tbClockGen clk0
	(
		.clkFSM(clkFSM),
		.resetFSM(resetFSM)
	);

	lcdHexDisplay dut0
	(
		.clkFSM(clkFSM),
		.resetFSM(resetFSM),
		.display(display),
		.nextString(nextString),
		.values(values),
		.lcd(lcd),
		.state(state)
	);

	// LCD latches RS and data on the falling edge of E
	always @(negedge lcd.e)
	begin
		if (!resetFSM)
		begin
			busLog.push_back(lcd);
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	function automatic logic [7:0] nibbleChar(input logic [3:0] n);
		string digits;
		digits = "0123456789ABCDEF";
		return digits[n];
	endfunction

	function automatic logic [63:0] hexString(input logic [31:0] word);
		logic [63:0] s;
		int n;
		for (n = 0; n < 8; n++)
		begin
			s[63 - 8*n -: 8] = nibbleChar(word[31 - 4*n -: 4]);
		end
		return s;
	endfunction

	task automatic failAndStop();
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkByte(input string name, input logic expRs, input logic [7:0] expData,
		input lcdBus_t got);
		if (got.rs !== expRs || got.data !== expData)
		begin
			$display("ERR %s: expected rs=%0b data=%02h, actual rs=%0b data=%02h",
				name, expRs, expData, got.rs, got.data);
			failAndStop();
		end
	endtask

	task automatic checkState(input string name, input seqState_t exp, input seqState_t got);
		if (got !== exp)
		begin
			$display("ERR %s: expected state %s, actual state %s (%0d)",
				name, exp.name(), got.name(), got);
			failAndStop();
		end
	endtask

	task automatic checkCount(input string name, input int exp, input int got);
		if (got != exp)
		begin
			$display("ERR %s: expected %0d bytes, actual %0d", name, exp, got);
			failAndStop();
		end
	endtask

	task automatic waitForState(input seqState_t target, input int limit, input string what);
		int cycles;
		cycles = 0;
		while (state !== target)
		begin
			@(negedge clkFSM);
			cycles++;
			if (cycles > limit)
			begin
				$display("Timeout: state never reached %s during %s", target.name(), what);
				failAndStop();
			end
		end
	endtask

	task automatic popByte(input string what, output lcdBus_t got);
		int cycles;
		cycles = 0;
		while (busLog.size() == 0)
		begin
			@(negedge clkFSM);
			cycles++;
			if (cycles > BYTE_TIMEOUT)
			begin
				$display("Timeout: no LCD byte arrived during %s", what);
				failAndStop();
			end
		end
		got = busLog.pop_front();
	endtask

	task automatic buildTable();
		logic [31:0] seed;
		int r;
		seed = 32'h585e;
		rowVals[0] = 32'h00000000;
		rowChars[0] = "00000000";
		rowNames[0] = "zeros";
		rowVals[1] = 32'hFFFFFFFF;
		rowChars[1] = "FFFFFFFF";
		rowNames[1] = "ones";
		rowVals[2] = 32'hA53CA53C;
		rowChars[2] = "A53CA53C";
		rowNames[2] = "mixA5";
		rowVals[3] = 32'h3CA53CA5;
		rowChars[3] = "3CA53CA5";
		rowNames[3] = "mix3C";
		for (r = 4; r < NUM_ROWS; r++)
		begin
			seed = xorshift32(seed);
			rowVals[r] = seed;
			rowChars[r] = hexString(seed);
			rowNames[r] = $sformatf("rand%0d", r - 4);
		end
	endtask

	initial
	begin
		lcdBus_t got;
		int i;
		int k;
		display = 1'b0;
		nextString = 1'b0;
		values = '0;
		buildTable();

		waitForState(ready, INIT_TIMEOUT, "power-up");
		checkCount("init bytes before ready", 4, busLog.size());
		for (k = 0; k < 4; k++)
		begin
			popByte("init list", got);
			checkByte($sformatf("init cmd %0d", k), 1'b0, initExpect[k], got);
		end

		for (i = 0; i < NUM_ROWS; i++)
		begin
			waitForState(ready, ROW_TIMEOUT, rowNames[i]);
			values = rowVals[i];
			display = 1'b1;
			@(negedge clkFSM);
			display = 1'b0;
			values = ~rowVals[i];	// Must not reach the screen
			checkState({rowNames[i], " accept"}, clear0, state);

			waitForState(finish, ROW_TIMEOUT, rowNames[i]);
			popByte(rowNames[i], got);
			checkByte({rowNames[i], " clear"}, 1'b0, 8'h01, got);
			for (k = 0; k < 8; k++)
			begin
				popByte(rowNames[i], got);
				checkByte($sformatf("%s char %0d", rowNames[i], k), 1'b1,
					rowChars[i][63 - 8*k -: 8], got);
			end
			checkCount({rowNames[i], " byte count"}, 0, busLog.size());

			// Strobe in finish is ignored
			display = 1'b1;
			@(negedge clkFSM);
			display = 1'b0;
			repeat (QUIET_CYC) @(negedge clkFSM);
			checkCount({rowNames[i], " quiet in finish"}, 0, busLog.size());
			checkState({rowNames[i], " hold"}, finish, state);

			nextString = 1'b1;
			@(negedge clkFSM);
			nextString = 1'b0;
			checkState({rowNames[i], " next"}, idle, state);
		end
		waitForState(ready, ROW_TIMEOUT, "final return");

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/lcdHexDisplay_asserts.sv
/*
	LCD bus and handshake assertions
	Bound into the LCD controller, where the sequencer requests,
	the controller replies and the LCD pins all meet.
*/
`timescale 1ns/1ps
`default_nettype none

module lcdHexDisplay_asserts
(
	input wire logic clkFSM,
	input wire logic resetFSM,
	input wire logic writeStart,
	input wire logic clrLCD,
	input wire logic initDone,
	input wire logic writeDone,
	input wire lcdPkg::lcdBus_t lcd
);

	reqNeedsInit: assert property (@(posedge clkFSM) disable iff (resetFSM)
		(writeStart || clrLCD) |-> initDone)
		else $error("write or clear request raised while initDone is low");

	donePulse: assert property (@(posedge clkFSM) disable iff (resetFSM)
		writeDone |=> !writeDone)
		else $error("writeDone stayed high for more than one cycle");

	rwLow: assert property (@(posedge clkFSM) disable iff (resetFSM)
		!lcd.rw)
		else $error("LCD RW pin driven high");

	// Data must not move inside an enable pulse
	dataStable: assert property (@(posedge clkFSM) disable iff (resetFSM)
		(lcd.e && $past(lcd.e)) |-> $stable(lcd.data))
		else $error("LCD data changed while E was high");

endmodule

bind lcdController lcdHexDisplay_asserts asserts0
(
	.clkFSM(clkFSM),
	.resetFSM(resetFSM),
	.writeStart(writeStart),
	.clrLCD(clrLCD),
	.initDone(initDone),
	.writeDone(writeDone),
	.lcd(lcd)
);

`default_nettype wire

// File: tb/tbClockGen.sv
/*
	Testbench clock and reset
	Makes clkFSM with a 40 ns period and holds resetFSM high
	for the first 5 rising edges.
*/
`timescale 1ns/1ps
`default_nettype none

module tbClockGen
(
	output logic clkFSM,
	output logic resetFSM
);

	localparam int HALF_PERIOD_NS = 20;
	localparam int RESET_CYC = 5;

	initial
	begin
		clkFSM = 1'b0;
		forever
		begin
			#HALF_PERIOD_NS clkFSM = ~clkFSM;
		end
	end

	initial
	begin
		resetFSM = 1'b1;
		repeat (RESET_CYC) @(posedge clkFSM);
		@(negedge clkFSM);	// Release away from the active edge
		resetFSM = 1'b0;
	end

endmodule

`default_nettype wire

// File: verilog/lcdHexDisplay.sv
/*
	LCD hex display top level
	Connects the display sequencer to the LCD controller.
	Shows A, X, Y and OP as eight hex characters.
*/
`timescale 1ns/1ps
`default_nettype none

module lcdHexDisplay
(
	input wire logic clkFSM,
	input wire logic resetFSM,
	input wire logic display,
	input wire logic nextString,
	input wire dispPkg::regSet_t values,
	output lcdPkg::lcdBus_t lcd,
	output dispPkg::seqState_t state
);

	logic [7:0] charData;
	logic writeStart;
	logic clrLCD;
	logic initDone;
	logic writeDone;

	displaySequencer seq0
	(
		.clkFSM(clkFSM),
		.resetFSM(resetFSM),
		.initDone(initDone),
		.writeDone(writeDone),
		.nextString(nextString),
		.display(display),
		.values(values),
		.charData(charData),
		.writeStart(writeStart),
		.clrLCD(clrLCD),
		.state(state)
	);

	lcdController ctrl0
	(
		.clkFSM(clkFSM),
		.resetFSM(resetFSM),
		.charData(charData),
		.writeStart(writeStart),
		.clrLCD(clrLCD),
		.initDone(initDone),
		.writeDone(writeDone),
		.lcd(lcd)
	);

endmodule

`default_nettype wire

// File: verilog/lcdController.sv
/*
	LCD controller
	Runs the power-up wait and the init command list, then serves
	character writes and clear requests on an 8-bit HD44780-style bus.
	All waits are fixed cycle counts and RW is held low.
	initDone is low during init and during every clear.
*/
`timescale 1ns/1ps
`default_nettype none

module lcdController
(
	input wire logic clkFSM,
	input wire logic resetFSM,
	input wire logic [7:0] charData,
	input wire logic writeStart,
	input wire logic clrLCD,
	output logic initDone,
	output logic writeDone,
	output lcdPkg::lcdBus_t lcd
);

	import lcdPkg::*;

	typedef enum logic [2:0]
	{
		powerUp,
		enHigh,
		enHold,
		byteWait,
		serve
	} ctlState_t;

	ctlState_t ctlState;
	logic [CNT_W-1:0] count;
	logic [INIT_IDX_W-1:0] initIdx;
	logic initPhase;	// Still walking INIT_CMDS
	logic lastInit;
	logic isClear;
	logic countZero;
	logic busE;
	logic busRs;
	logic [7:0] busData;

	assign lastInit = (initIdx == INIT_IDX_W'(INIT_LEN - 1));
	assign isClear = !busRs && (busData == CMD_CLEAR);
	assign countZero = (count == '0);

	assign lcd = '{e: busE, rs: busRs, rw: 1'b0, data: busData};

	always_ff @(posedge clkFSM)
	begin
		if (resetFSM)
		begin
			ctlState <= powerUp;
			count <= CNT_W'(POWERUP_CYC - 1);
			initIdx <= '0;
			initPhase <= 1'b1;
			initDone <= 1'b0;
			writeDone <= 1'b0;
			busE <= 1'b0;
		end
		else
		begin
			writeDone <= 1'b0;
			case (ctlState)
				powerUp:
				begin
					if (countZero)
					begin
						busE <= 1'b1;	// First init command
						count <= CNT_W'(EPULSE_CYC - 1);
						ctlState <= enHigh;
					end
					else
					begin
						count <= count - 1'b1;
					end
				end
				enHigh:
				begin
					if (countZero)
					begin
						busE <= 1'b0;
						count <= CNT_W'(HOLD_CYC - 1);
						ctlState <= enHold;
					end
					else
					begin
						count <= count - 1'b1;
					end
				end
				enHold:
				begin
					if (countZero)
					begin
						count <= isClear ? CNT_W'(CLEAR_WAIT_CYC - 1) : CNT_W'(WRITE_WAIT_CYC - 1);
						ctlState <= byteWait;
					end
					else
					begin
						count <= count - 1'b1;
					end
				end
				byteWait:
				begin
					if (!countZero)
					begin
						count <= count - 1'b1;
					end
					else if (initPhase && !lastInit)
					begin
						initIdx <= initIdx + 1'b1;	// Next init command
						busE <= 1'b1;
						count <= CNT_W'(EPULSE_CYC - 1);
						ctlState <= enHigh;
					end
					else
					begin
						initPhase <= 1'b0;
						ctlState <= serve;
						if (busRs)
						begin
							writeDone <= 1'b1;
						end
						else
						begin
							initDone <= 1'b1;	// After init list or clear
						end
					end
				end
				serve:
				begin
					if (clrLCD)
					begin
						initDone <= 1'b0;
						busE <= 1'b1;
						count <= CNT_W'(EPULSE_CYC - 1);
						ctlState <= enHigh;
					end
					else if (writeStart)
					begin
						busE <= 1'b1;
						count <= CNT_W'(EPULSE_CYC - 1);
						ctlState <= enHigh;
					end
				end
				default:
				begin
					ctlState <= powerUp;
				end
			endcase
		end
	end

	// RS and data only change when a byte is launched
	always_ff @(posedge clkFSM)
	begin
		if (ctlState == powerUp && countZero)
		begin
			busRs <= 1'b0;
			busData <= INIT_CMDS[initIdx];
		end
		else if (ctlState == byteWait && countZero && initPhase && !lastInit)
		begin
			busRs <= 1'b0;
			busData <= INIT_CMDS[initIdx + 1'b1];
		end
		else if (ctlState == serve && clrLCD)
		begin
			busRs <= 1'b0;
			busData <= CMD_CLEAR;
		end
		else if (ctlState == serve && writeStart)
		begin
			busRs <= 1'b1;	// Character data
			busData <= charData;
		end
	end

endmodule

`default_nettype wire

// File: verilog/displaySequencer.sv
/*
	Display sequencer
	Waits for the LCD to come up, then on each display strobe clears
	the screen and writes A, X, Y and OP as eight hex characters.
	The register values are captured when the strobe is accepted.
	Rests in finish until nextString.
*/
`timescale 1ns/1ps
`default_nettype none

module displaySequencer
(
	input wire logic clkFSM,
	input wire logic resetFSM,
	input wire logic initDone,
	input wire logic writeDone,
	input wire logic nextString,
	input wire logic display,
	input wire dispPkg::regSet_t values,
	output logic [7:0] charData,
	output logic writeStart,
	output logic clrLCD,
	output dispPkg::seqState_t state
);

	import dispPkg::*;

	seqState_t nextState;
	regSet_t held;	// Snapshot of values
	logic [DIGIT_W-1:0] digit;
	logic [$bits(regSet_t)-1:0] shifted;
	logic [3:0] nibble;
	logic [7:0] digitChar;
	logic lastDigit;

	// Digit 0 is A high nibble, digit 7 is OP low nibble
	assign shifted = held << {digit, 2'b00};
	assign nibble = shifted[$bits(regSet_t)-1 -: 4];
	assign digitChar = hexToAscii(nibble);
	assign lastDigit = (digit == DIGIT_W'(NUM_DIGITS - 1));

	always_comb
	begin
		nextState = state;
		charData = 8'h00;
		writeStart = 1'b0;
		clrLCD = 1'b0;
		case (state)
			idle:
			begin
				if (initDone)
				begin
					nextState = ready;
				end
			end
			ready:
			begin
				if (display)
				begin
					nextState = clear0;
				end
			end
			clear0:
			begin
				clrLCD = 1'b1;
				nextState = waitClear;
			end
			waitClear:
			begin
				if (initDone)	// Clear wait done
				begin
					nextState = dataChar;
				end
			end
			dataChar:
			begin
				charData = digitChar;
				writeStart = 1'b1;
				nextState = waitChar;
			end
			waitChar:
			begin
				charData = digitChar;	// Held for the whole write
				if (writeDone)
				begin
					nextState = lastDigit ? finish : dataChar;
				end
			end
			finish:
			begin
				if (nextString)
				begin
					nextState = idle;
				end
			end
			default:
			begin
				nextState = idle;
			end
		endcase
	end

	always_ff @(posedge clkFSM)
	begin
		if (resetFSM)
		begin
			state <= idle;
			digit <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == clear0)
			begin
				digit <= '0;
			end
			else if (state == waitChar && writeDone)
			begin
				digit <= digit + 1'b1;
			end
		end
	end

	always_ff @(posedge clkFSM)
	begin
		if (state == ready && display)
		begin
			held <= values;
		end
	end

endmodule

`default_nettype wire

// File: verilog/dispPkg.sv
/*
	Display content package
	Register set shown on the LCD, sequencer states,
	digit count and the nibble to ASCII conversion.
*/
`default_nettype none

package dispPkg;

	typedef struct packed
	{
		logic [7:0] a;
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] op;
	} regSet_t;

	localparam int NUM_DIGITS = 8;	// Two per register
	localparam int DIGIT_W = $clog2(NUM_DIGITS);

	typedef enum logic [2:0]
	{
		idle,
		ready,
		clear0,
		waitClear,
		dataChar,
		waitChar,
		finish
	} seqState_t;

	// Uppercase hex digit
	function automatic logic [7:0] hexToAscii(input logic [3:0] nib);
		if (nib < 4'd10)
		begin
			return 8'h30 + {4'h0, nib};	// '0'..'9'
		end
		return 8'h37 + {4'h0, nib};	// 'A'..'F'
	endfunction

endpackage

`default_nettype wire

// File: verilog/lcdPkg.sv
/*
	LCD bus package
	Pin bundle of the HD44780-style interface, command codes,
	the power-up command list and the bus timing counts.
*/
`include "lcdTiming.svh"
`default_nettype none

package lcdPkg;

	typedef struct packed
	{
		logic e;
		logic rs;
		logic rw;
		logic [7:0] data;
	} lcdBus_t;

	localparam logic [7:0] CMD_CLEAR = 8'h01;

	localparam int INIT_LEN = 4;
	localparam int INIT_IDX_W = $clog2(INIT_LEN);

	// Function set, display on, entry mode, clear
	localparam logic [0:INIT_LEN-1][7:0] INIT_CMDS =
	{
		8'h38,
		8'h0C,
		8'h06,
		CMD_CLEAR
	};

	localparam int POWERUP_CYC = `LCD_POWERUP_CYC;
	localparam int EPULSE_CYC = `LCD_EPULSE_CYC;
	localparam int HOLD_CYC = `LCD_HOLD_CYC;
	localparam int WRITE_WAIT_CYC = `LCD_WRITE_WAIT_CYC;
	localparam int CLEAR_WAIT_CYC = `LCD_CLEAR_WAIT_CYC;

	// Power-up is the longest wait
	localparam int CNT_W = $clog2(POWERUP_CYC + 1);

endpackage

`default_nettype wire

// File: include/lcdTiming.svh
/*
	LCD timing constants
	Cycle counts for the character LCD family driven by this design.
	Counts are scaled down so simulation stays short.
*/
`ifndef LCD_TIMING_SVH
`define LCD_TIMING_SVH
`default_nettype none

`define LCD_POWERUP_CYC 200	// Wait after reset
`define LCD_EPULSE_CYC 12	// E high time
`define LCD_HOLD_CYC 4	// Data hold after E falls
`define LCD_WRITE_WAIT_CYC 40	// Settle after a normal byte
`define LCD_CLEAR_WAIT_CYC 100	// Settle after a clear

`default_nettype wire
`endif
